// File: src/lsu_pkg.sv
/*
 * Shared definitions for the MIPS load/store unit.
 * Opcode encodings, bus widths and store buffer sizing.
 */

package lsu_pkg;

   // ------------------------------
   // Opcodes, MIPS major opcode field
   // ------------------------------
   typedef enum logic [5:0] {
      // Loads live in 6'b100xxx
      op_lb  = 6'h20,
      op_lh  = 6'h21,
      op_lwl = 6'h22,
      op_lw  = 6'h23,
      op_lbu = 6'h24,
      op_lhu = 6'h25,
      op_lwr = 6'h26,
      // Stores live in 6'b101xxx
      op_sb  = 6'h28,
      op_sh  = 6'h29,
      op_swl = 6'h2A,
      op_sw  = 6'h2B,
      op_swr = 6'h2E
   } mem_op_e;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int ADDR_W      = 32;
   localparam int WORD_ADDR_W = 30;
   localparam int DATA_W      = 32;
   localparam int BE_W        = 4;

   // Store buffer has 2**SB_DEPTH_BITS slots, one always left free
   localparam int SB_DEPTH_BITS = 3;

   // ------------------------------
   // Simulation environment constants
   // ------------------------------
   localparam int          MEM_WORDS         = 1024;
   localparam int          READ_LATENCY      = 2;
   localparam logic [31:0] LFSR_SEED         = 32'hb870_4b4d;
   localparam int          TIMEOUT_PER_ENTRY = 200;

endpackage

// File: src/store_align.sv
/*
 * Store formatting, big-endian.
 * Rotates the register value into byte lane position and
 * builds the byte enables for SW, SH, SB, SWL and SWR.
 */

`timescale 1ns/1ps

module store_align (
   input  lsu_pkg::mem_op_e            op,
   input  logic [1:0]                  byte_offset,
   input  logic [lsu_pkg::DATA_W-1:0]  rt_val,
   output logic [lsu_pkg::DATA_W-1:0]  store_data,
   output logic [lsu_pkg::BE_W-1:0]    store_byteena
);
   import lsu_pkg::*;

   logic [1:0]          rot_delta;
   logic [1:0]          rotation;
   logic [2*DATA_W-1:0] doubled;

   // Extra rotation on top of the address offset
   always_comb begin
      case (op)
         op_sh:   rot_delta = 2'd2;
         op_sb:   rot_delta = 2'd1;
         op_swr:  rot_delta = 2'd1;
         default: rot_delta = 2'd0;
      endcase
   end

   // Wraps modulo 4 by width
   assign rotation = byte_offset + rot_delta;

   // Byte-wise right rotate through a doubled copy
   assign doubled    = {rt_val, rt_val};
   assign store_data = doubled[rotation*8 +: DATA_W];

   // ------------------------------
   // Byte enables, bit 3 is byte 0
   // ------------------------------
   always_comb begin
      case (op)
         op_sw:   store_byteena = 4'hF;
         // Upper pair at offset 0, lower pair at offset 2
         op_sh:   store_byteena = byte_offset[1] ? 4'h3 : 4'hC;
         op_sb:   store_byteena = 4'h8 >> byte_offset;
         // Left part runs from offset to end of word
         op_swl:  store_byteena = 4'hF >> byte_offset;
         // Right part runs from start of word to offset
         op_swr:  store_byteena = 4'hF << ~byte_offset;
         default: store_byteena = 4'h0;
      endcase
   end

endmodule

// File: src/store_buffer.sv
/*
 * Store buffer.
 * Circular queue of pending word stores waiting for the memory bus.
 */

`timescale 1ns/1ps

module store_buffer (
   input  logic                              clock,
   input  logic                              arst_n,
   input  logic                              push,
   input  logic [lsu_pkg::WORD_ADDR_W-1:0]   push_address,
   input  logic [lsu_pkg::DATA_W-1:0]        push_data,
   input  logic [lsu_pkg::BE_W-1:0]          push_byteena,
   input  logic                              pop,
   output logic                              full,
   output logic                              empty,
   output logic [lsu_pkg::WORD_ADDR_W-1:0]   head_address,
   output logic [lsu_pkg::DATA_W-1:0]        head_data,
   output logic [lsu_pkg::BE_W-1:0]          head_byteena
);
   import lsu_pkg::*;

   localparam int SLOTS = 1 << SB_DEPTH_BITS;

   // Entry storage
   logic [WORD_ADDR_W-1:0] addr_mem [SLOTS];
   logic [DATA_W-1:0]      data_mem [SLOTS];
   logic [BE_W-1:0]        be_mem   [SLOTS];

   // Pointers wrap naturally at the slot count
   logic [SB_DEPTH_BITS-1:0] wp;
   logic [SB_DEPTH_BITS-1:0] rp;
   logic [SB_DEPTH_BITS-1:0] wp_next;

   assign wp_next = wp + 1'b1;

   // Full keeps one slot free so full and empty stay distinct
   assign full  = (wp_next == rp);
   assign empty = (wp == rp);

   // ------------------------------
   // Pointer update
   // ------------------------------
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wp <= '0;
         rp <= '0;
      end else begin
         if (push && !full)
            wp <= wp_next;
         if (pop && !empty)
            rp <= rp + 1'b1;
      end
   end

   // Entry write, visible at the head from the next cycle
   always_ff @(posedge clock) begin
      if (push && !full) begin
         addr_mem[wp] <= push_address;
         data_mem[wp] <= push_data;
         be_mem[wp]   <= push_byteena;
      end
   end

   // Oldest entry
   assign head_address = addr_mem[rp];
   assign head_data    = data_mem[rp];
   assign head_byteena = be_mem[rp];

endmodule

// File: src/lsu_control.sv
/*
 * Load/store control and memory bus master.
 * Accepts requests, drains the store buffer and issues
 * the single outstanding load once the buffer is empty.
 */

`timescale 1ns/1ps

module lsu_control (
   input  logic                              clock,
   input  logic                              arst_n,
   input  logic                              req_valid,
   input  lsu_pkg::mem_op_e                  req_op,
   input  logic                              full,
   input  logic                              empty,
   input  logic [lsu_pkg::WORD_ADDR_W-1:0]   head_address,
   input  logic [lsu_pkg::DATA_W-1:0]        head_data,
   input  logic [lsu_pkg::BE_W-1:0]          head_byteena,
   input  logic [lsu_pkg::ADDR_W-1:0]        req_address,
   input  logic                              mem_waitrequest,
   input  logic                              mem_readdatavalid,
   output logic                              req_ready,
   output logic                              push,
   output logic                              pop,
   output logic                              load_start,
   output logic [lsu_pkg::WORD_ADDR_W-1:0]   mem_address,
   output logic                              mem_read,
   output logic                              mem_write,
   output logic [lsu_pkg::DATA_W-1:0]        mem_writedata,
   output logic [lsu_pkg::BE_W-1:0]          mem_byteena
);
   import lsu_pkg::*;

   logic                   is_load;
   logic                   is_store;
   logic                   accept;
   logic                   load_pending;
   logic                   load_waiting;
   logic                   bus_free;
   logic                   issue_read;
   logic [WORD_ADDR_W-1:0] load_address;

   // Opcode class
   always_comb begin
      is_load  = 1'b0;
      is_store = 1'b0;
      case (req_op)
         op_lb, op_lh, op_lwl, op_lw, op_lbu, op_lhu, op_lwr: is_load  = 1'b1;
         op_sb, op_sh, op_swl, op_sw, op_swr:                 is_store = 1'b1;
         default: ;
      endcase
   end

   // Back-pressure while a load is in flight or the buffer is full
   assign req_ready  = !load_pending && !full;
   assign accept     = req_valid && req_ready;
   assign push       = accept && is_store;
   assign load_start = accept && is_load;

   // ------------------------------
   // Bus arbitration
   // ------------------------------
   // Command register can take a new command when idle or just taken
   assign bus_free   = !(mem_read || mem_write) || !mem_waitrequest;
   // Stores go first, the load only sees an empty buffer
   assign pop        = bus_free && !empty;
   assign issue_read = bus_free && empty && load_waiting;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         load_pending <= 1'b0;
         load_waiting <= 1'b0;
         mem_read     <= 1'b0;
         mem_write    <= 1'b0;
      end else begin
         if (bus_free) begin
            mem_read  <= issue_read;
            mem_write <= pop;
         end
         if (load_start) begin
            load_pending <= 1'b1;
            load_waiting <= 1'b1;
         end
         if (issue_read)
            load_waiting <= 1'b0;
         // Outstanding until the data word comes back
         if (mem_readdatavalid)
            load_pending <= 1'b0;
      end
   end

   // Command payload
   always_ff @(posedge clock) begin
      if (load_start)
         load_address <= req_address[ADDR_W-1:2];
      if (pop) begin
         mem_address   <= head_address;
         mem_writedata <= head_data;
         mem_byteena   <= head_byteena;
      end else if (issue_read) begin
         mem_address <= load_address;
         mem_byteena <= 4'hF;
      end
   end

endmodule

// File: src/load_align.sv
/*
 * Load extraction, big-endian.
 * Selects and extends the loaded bytes and merges LWL/LWR
 * with the target register, then registers the result.
 */

`timescale 1ns/1ps

module load_align (
   input  logic                        clock,
   input  logic                        arst_n,
   input  logic                        load_start,
   input  lsu_pkg::mem_op_e            op,
   input  logic [1:0]                  byte_offset,
   input  logic [lsu_pkg::DATA_W-1:0]  rt_val,
   input  logic [lsu_pkg::DATA_W-1:0]  mem_readdata,
   input  logic                        mem_readdatavalid,
   output logic [lsu_pkg::DATA_W-1:0]  load_res,
   output logic                        resp_valid
);
   import lsu_pkg::*;

   // Load context held while the read is in flight
   mem_op_e     ld_op;
   logic [1:0]  ld_offset;
   logic [DATA_W-1:0] ld_rt;

   logic [DATA_W-1:0] result;
   logic [7:0] aa, bb, cc, dd;
   logic [7:0] ta, tb, tc, td;
   logic [7:0] sa, sb, sc, sd;

   always_ff @(posedge clock) begin
      if (load_start) begin
         ld_op     <= op;
         ld_offset <= byte_offset;
         ld_rt     <= rt_val;
      end
   end

   // Memory bytes, aa at the lowest address
   assign {aa, bb, cc, dd} = mem_readdata;
   // Target register bytes
   assign {ta, tb, tc, td} = ld_rt;
   // Sign fill per byte
   assign sa = {8{aa[7]}};
   assign sb = {8{bb[7]}};
   assign sc = {8{cc[7]}};
   assign sd = {8{dd[7]}};

   // ------------------------------
   // Extraction network
   // ------------------------------
   always_comb begin
      case (ld_op)
         op_lh:  result = ld_offset[1] ? {sc, sc, cc, dd} : {sa, sa, aa, bb};
         op_lhu: result = ld_offset[1] ? {16'h0, cc, dd}  : {16'h0, aa, bb};
         op_lb:
            case (ld_offset)
               2'd0:    result = {sa, sa, sa, aa};
               2'd1:    result = {sb, sb, sb, bb};
               2'd2:    result = {sc, sc, sc, cc};
               default: result = {sd, sd, sd, dd};
            endcase
         op_lbu:
            case (ld_offset)
               2'd0:    result = {24'h0, aa};
               2'd1:    result = {24'h0, bb};
               2'd2:    result = {24'h0, cc};
               default: result = {24'h0, dd};
            endcase
         // Memory bytes fill from the top, register keeps the rest
         op_lwl:
            case (ld_offset)
               2'd0:    result = {aa, bb, cc, dd};
               2'd1:    result = {bb, cc, dd, td};
               2'd2:    result = {cc, dd, tc, td};
               default: result = {dd, tb, tc, td};
            endcase
         // Memory bytes fill from the bottom
         op_lwr:
            case (ld_offset)
               2'd0:    result = {ta, tb, tc, aa};
               2'd1:    result = {ta, tb, aa, bb};
               2'd2:    result = {ta, aa, bb, cc};
               default: result = {aa, bb, cc, dd};
            endcase
         default: result = mem_readdata;
      endcase
   end

   always_ff @(posedge clock) begin
      if (mem_readdatavalid)
         load_res <= result;
   end

   // One pulse per returned word
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n)
         resp_valid <= 1'b0;
      else
         resp_valid <= mem_readdatavalid;
   end

endmodule

// File: src/lsu_top.sv
/*
 * MIPS load/store unit top level.
 * Request port in, load responses out, word bus to memory.
 */

`timescale 1ns/1ps

module lsu_top (
   input  logic                              clock,
   input  logic                              arst_n,
   // Request port
   input  logic                              req_valid,
   output logic                              req_ready,
   input  lsu_pkg::mem_op_e                  req_op,
   input  logic [lsu_pkg::ADDR_W-1:0]        req_address,
   input  logic [lsu_pkg::DATA_W-1:0]        req_rt_val,
   // Response port
   output logic                              resp_valid,
   output logic [lsu_pkg::DATA_W-1:0]        load_res,
   // Memory bus
   output logic [lsu_pkg::WORD_ADDR_W-1:0]   mem_address,
   output logic                              mem_read,
   output logic                              mem_write,
   output logic [lsu_pkg::DATA_W-1:0]        mem_writedata,
   output logic [lsu_pkg::BE_W-1:0]          mem_byteena,
   input  logic                              mem_waitrequest,
   input  logic [lsu_pkg::DATA_W-1:0]        mem_readdata,
   input  logic                              mem_readdatavalid
);
   import lsu_pkg::*;

   // ------------------------------
   // Internal wiring
   // ------------------------------
   logic [DATA_W-1:0]      store_data;
   logic [BE_W-1:0]        store_byteena;
   logic                   push, pop, full, empty;
   logic                   load_start;
   logic [WORD_ADDR_W-1:0] head_address;
   logic [DATA_W-1:0]      head_data;
   logic [BE_W-1:0]        head_byteena;

   store_align u_store_align (
      .op (req_op), .byte_offset (req_address[1:0]), .rt_val (req_rt_val),
      .store_data (store_data), .store_byteena (store_byteena)
   );

   // Buffer holds word addresses only
   store_buffer u_store_buffer (
      .clock (clock), .arst_n (arst_n),
      .push (push), .push_address (req_address[ADDR_W-1:2]),
      .push_data (store_data), .push_byteena (store_byteena), .pop (pop),
      .full (full), .empty (empty), .head_address (head_address),
      .head_data (head_data), .head_byteena (head_byteena)
   );

   lsu_control u_lsu_control (
      .clock (clock), .arst_n (arst_n), .req_valid (req_valid), .req_op (req_op),
      .full (full), .empty (empty), .head_address (head_address),
      .head_data (head_data), .head_byteena (head_byteena),
      .req_address (req_address), .mem_waitrequest (mem_waitrequest),
      .mem_readdatavalid (mem_readdatavalid), .req_ready (req_ready),
      .push (push), .pop (pop), .load_start (load_start),
      .mem_address (mem_address), .mem_read (mem_read), .mem_write (mem_write),
      .mem_writedata (mem_writedata), .mem_byteena (mem_byteena)
   );

   load_align u_load_align (
      .clock (clock), .arst_n (arst_n), .load_start (load_start),
      .op (req_op), .byte_offset (req_address[1:0]), .rt_val (req_rt_val),
      .mem_readdata (mem_readdata), .mem_readdatavalid (mem_readdatavalid),
      .load_res (load_res), .resp_valid (resp_valid)
   );

endmodule

// File: test/tb_mem_model.sv
/*
 * Word memory responder for the load/store unit testbench.
 * Random waitrequest from an LFSR, fixed read latency.
 */

`timescale 1ns/1ps

module tb_mem_model (
   input  logic                              clock,
   input  logic                              arst_n,
   input  logic                              hold,
   input  logic [lsu_pkg::WORD_ADDR_W-1:0]   mem_address,
   input  logic                              mem_read,
   input  logic                              mem_write,
   input  logic [lsu_pkg::DATA_W-1:0]        mem_writedata,
   input  logic [lsu_pkg::BE_W-1:0]          mem_byteena,
   output logic                              mem_waitrequest,
   output logic [lsu_pkg::DATA_W-1:0]        mem_readdata,
   output logic                              mem_readdatavalid
);
   import lsu_pkg::*;

   logic [31:0] mem [MEM_WORDS];
   logic [31:0] lfsr;
   logic [31:0] rd_word;
   logic        stall;
   logic        first_bit;
   int          rd_wait;
   int          i;
   int          b;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Forced stall from the testbench or a random one
   assign mem_waitrequest = hold || stall;

   initial begin
      lfsr              = LFSR_SEED;
      stall             = 1'b0;
      rd_wait           = 0;
      rd_word           = 32'h0;
      mem_readdata      = 32'h0;
      mem_readdatavalid = 1'b0;
      // Fill pattern mixes every address bit
      for (i = 0; i < MEM_WORDS; i++)
         mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
   end

   // ------------------------------
   // Command acceptance
   // ------------------------------
   always @(posedge clock) begin
      if (!arst_n) begin
         rd_wait = 0;
      end else begin
         if (rd_wait > 0)
            rd_wait = rd_wait - 1;
         if (mem_write && !mem_waitrequest)
            for (b = 0; b < 4; b++)
               if (mem_byteena[b])
                  mem[mem_address % MEM_WORDS][8*b +: 8] = mem_writedata[8*b +: 8];
         if (mem_read && !mem_waitrequest) begin
            rd_word = mem[mem_address % MEM_WORDS];
            rd_wait = READ_LATENCY;
         end
      end
   end

   // Outputs change mid-cycle, two LFSR bits per cycle
   always @(negedge clock) begin
      lfsr      = lfsr_next(lfsr);
      first_bit = lfsr[0];
      lfsr      = lfsr_next(lfsr);
      // Stall roughly one cycle in four
      stall             = first_bit && lfsr[0];
      mem_readdatavalid = (rd_wait == 1);
      mem_readdata      = rd_word;
   end

endmodule

// File: test/tb_lsu.sv
/*
 * Testbench for the MIPS load/store unit.
 * Table-driven requests checked against a shadow memory,
 * with bus and response monitors and a cycle watchdog.
 */

`timescale 1ns/1ps

module tb_lsu;
   import lsu_pkg::*;

   logic                   clock;
   logic                   arst_n;
   logic                   req_valid;
   logic                   req_ready;
   mem_op_e                req_op;
   logic [ADDR_W-1:0]      req_address;
   logic [DATA_W-1:0]      req_rt_val;
   logic                   resp_valid;
   logic [DATA_W-1:0]      load_res;
   logic [WORD_ADDR_W-1:0] mem_address;
   logic                   mem_read;
   logic                   mem_write;
   logic [DATA_W-1:0]      mem_writedata;
   logic [BE_W-1:0]        mem_byteena;
   logic                   mem_waitrequest;
   logic [DATA_W-1:0]      mem_readdata;
   logic                   mem_readdatavalid;
   logic                   mem_hold;

   // Stimulus table with one request per row
   mem_op_e     op_tab[$];
   logic [31:0] addr_tab[$];
   logic [31:0] rt_tab[$];
   logic [31:0] exp_tab[$];
   logic        hold_tab[$];

   // Expected traffic with write items packed as {word address, byte enables, data}
   logic [31:0] shadow [MEM_WORDS];
   logic [65:0] exp_writes[$];
   logic [31:0] exp_loads[$];
   logic [65:0] write_item;

   int errors      = 0;
   int checks      = 0;
   int cycles      = 0;
   int cycle_limit = TIMEOUT_PER_ENTRY;
   int loads_sent  = 0;
   int resp_seen   = 0;
   int i;

   lsu_top dut0 (.*);

   tb_mem_model mem0 (.hold(mem_hold), .*);

   initial begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, got, expected);
      end
   endtask

   function automatic logic is_store(mem_op_e op);
      return op == op_sb || op == op_sh || op == op_swl || op == op_sw || op == op_swr;
   endfunction

   // ------------------------------
   // Reference rules with lane 0 at the lowest address
   // ------------------------------
   function automatic logic [35:0] format_store(mem_op_e op, logic [1:0] off, logic [31:0] rt);
      logic [31:0] data;
      logic [3:0]  be;
      int          o;
      int          rot;
      int          lane;
      o   = off;
      rot = (op == op_sh) ? 2 : (op == op_sb || op == op_swr) ? 1 : 0;
      for (lane = 0; lane < 4; lane++) begin
         // Right rotation moves lane L-rot into lane L
         data[31-8*lane -: 8] = rt[31-8*((lane - (o + rot) + 8) % 4) -: 8];
         case (op)
            op_sw:   be[3-lane] = 1'b1;
            op_sh:   be[3-lane] = (lane / 2 == o / 2);
            op_sb:   be[3-lane] = (lane == o);
            op_swl:  be[3-lane] = (lane >= o);
            op_swr:  be[3-lane] = (lane <= o);
            default: be[3-lane] = 1'b0;
         endcase
      end
      return {be, data};
   endfunction

   function automatic logic [31:0] extract_load(mem_op_e op, logic [1:0] off,
                                                logic [31:0] word, logic [31:0] rt);
      logic [7:0]  m [4];
      logic [31:0] res;
      int          o;
      int          h;
      int          j;
      o   = off;
      h   = o & 2;
      res = rt;
      for (j = 0; j < 4; j++)
         m[j] = word[31-8*j -: 8];
      case (op)
         op_lw:  res = word;
         op_lh:  res = {{16{m[h][7]}}, m[h], m[h+1]};
         op_lhu: res = {16'h0, m[h], m[h+1]};
         op_lb:  res = {{24{m[o][7]}}, m[o]};
         op_lbu: res = {24'h0, m[o]};
         // LWL fills from the top, LWR from the bottom
         op_lwl: for (j = 0; j < 4 - o; j++) res[31-8*j -: 8] = m[j+o];
         op_lwr: for (j = 3 - o; j < 4; j++) res[31-8*j -: 8] = m[j-3+o];
         default: res = 32'h0;
      endcase
      return res;
   endfunction

   function automatic mem_op_e store_op(int k);
      case (k % 5)
         0:       return op_sw;
         1:       return op_sh;
         2:       return op_sb;
         3:       return op_swl;
         default: return op_swr;
      endcase
   endfunction

   // Appends a row and keeps the shadow memory in request order
   task automatic add_entry(mem_op_e op, logic [31:0] addr, logic [31:0] rt, logic hold);
      logic [35:0] st;
      int          w;
      int          b;
      w  = (addr >> 2) % MEM_WORDS;
      st = format_store(op, addr[1:0], rt);
      op_tab.push_back(op);
      addr_tab.push_back(addr);
      rt_tab.push_back(rt);
      hold_tab.push_back(hold);
      if (is_store(op)) begin
         exp_tab.push_back(32'h0);
         for (b = 0; b < 4; b++)
            if (st[32+b])
               shadow[w][8*b +: 8] = st[8*b +: 8];
      end else begin
         exp_tab.push_back(extract_load(op, addr[1:0], shadow[w], rt));
      end
   endtask

   task automatic build_table();
      mem_op_e     op;
      logic [31:0] a;
      int          k;
      int          o;
      int          w;
      w = 0;
      // Every store format at its legal offsets with a word read back
      for (k = 0; k < 5; k++)
         for (o = 0; o < 4; o++) begin
            op = store_op(k);
            if (!((op == op_sw && o != 0) || (op == op_sh && o % 2 != 0))) begin
               a = 32'h200 + 4 * w + o;
               add_entry(op, a, 32'h1a2b_3c4d ^ (w * 32'h0107_0b0d), 1'b0);
               add_entry(op_lw, a & ~32'h3, 32'h0, 1'b0);
               w++;
            end
         end
      // Sub-word loads on a stored word and a fill word
      add_entry(op_sw, 32'h300, 32'h8f01_7fc3, 1'b0);
      for (w = 0; w < 2; w++)
         for (o = 0; o < 4; o++) begin
            a = 32'h300 + 4 * w + o;
            add_entry(op_lb, a, 32'h5555_5555, 1'b0);
            add_entry(op_lbu, a, 32'h5555_5555, 1'b0);
            if (o % 2 == 0) begin
               add_entry(op_lh, a, 32'h5555_5555, 1'b0);
               add_entry(op_lhu, a, 32'h5555_5555, 1'b0);
            end
         end
      // Unaligned merges with a known target
      for (o = 0; o < 4; o++) begin
         add_entry(op_lwl, 32'h310 + o, 32'h1122_3344, 1'b0);
         add_entry(op_lwr, 32'h310 + o, 32'h1122_3344, 1'b0);
      end
      // Burst against a stalled bus followed by loads behind it
      for (k = 0; k < 8; k++) begin
         op = store_op(k);
         o  = (op == op_sw) ? 0 : (op == op_sh) ? (k % 2) * 2 : k % 4;
         add_entry(op, 32'h400 + 4 * k + o, 32'hc0de_0000 + k * 32'h0011_0101, 1'b1);
      end
      for (k = 0; k < 8; k++)
         add_entry(op_lw, 32'h400 + 4 * k, 32'h0, 1'b0);
   endtask

   task automatic apply_entry(int n);
      logic [35:0] st;
      @(negedge clock);
      req_valid   = 1'b1;
      req_op      = op_tab[n];
      req_address = addr_tab[n];
      req_rt_val  = rt_tab[n];
      // The buffer must be full when a stalled burst ends
      if (mem_hold && !hold_tab[n]) begin
         check_value("req_ready", req_ready, 32'h0);
         mem_hold = 1'b0;
      end
      while (!req_ready)
         @(negedge clock);
      // A new stall starts only once the previous load has returned
      mem_hold = hold_tab[n];
      @(posedge clock);
      if (is_store(op_tab[n])) begin
         st = format_store(op_tab[n], addr_tab[n][1:0], rt_tab[n]);
         exp_writes.push_back({addr_tab[n][31:2], st});
      end else begin
         exp_loads.push_back(exp_tab[n]);
         loads_sent++;
      end
   endtask

   // ------------------------------
   // Monitors
   // ------------------------------
   // Writes must leave in request order
   always @(posedge clock) begin
      if (arst_n && mem_write && !mem_waitrequest) begin
         if (exp_writes.size() == 0) begin
            errors++;
            $display("Write command seen on the bus with no store pending");
         end else begin
            write_item = exp_writes.pop_front();
            check_value("mem_address", mem_address, write_item[65:36]);
            check_value("mem_byteena", mem_byteena, write_item[35:32]);
            check_value("mem_writedata", mem_writedata, write_item[31:0]);
         end
      end
   end

   // One response per load sampled mid-cycle
   always @(negedge clock) begin
      if (resp_valid) begin
         resp_seen++;
         if (exp_loads.size() == 0) begin
            errors++;
            $display("Load response seen with no load outstanding");
         end else begin
            check_value("load_res", load_res, exp_loads.pop_front());
         end
      end
   end

   initial begin
      while (cycles < cycle_limit) begin
         @(posedge clock);
         cycles++;
      end
      errors++;
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("%0d errors in %0d checks", errors, checks);
      $display("Errors found");
      $finish;
   end

   initial begin
      req_valid   = 1'b0;
      req_op      = op_lw;
      req_address = 32'h0;
      req_rt_val  = 32'h0;
      mem_hold    = 1'b0;
      arst_n      = 1'b0;
      repeat (4) @(posedge clock);
      @(negedge clock);
      arst_n = 1'b1;
      // Idle bus after reset
      repeat (3) begin
         @(negedge clock);
         check_value("req_ready", req_ready, 32'h1);
         check_value("mem_read", mem_read, 32'h0);
         check_value("mem_write", mem_write, 32'h0);
         check_value("resp_valid", resp_valid, 32'h0);
      end
      for (i = 0; i < MEM_WORDS; i++)
         shadow[i] = mem0.mem[i];
      build_table();
      cycle_limit = cycles + (op_tab.size() + 2) * TIMEOUT_PER_ENTRY;
      for (i = 0; i < op_tab.size(); i++)
         apply_entry(i);
      @(negedge clock);
      req_valid = 1'b0;
      // Drain and allow time for stray pulses
      while (exp_loads.size() > 0 || exp_writes.size() > 0)
         @(negedge clock);
      repeat (4) @(negedge clock);
      check_value("resp_valid pulses", resp_seen, loads_sent);
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// File: files.f
src/lsu_pkg.sv
src/store_align.sv
src/store_buffer.sv
src/lsu_control.sv
src/load_align.sv
src/lsu_top.sv
test/tb_mem_model.sv
test/tb_lsu.sv

// File: Bender.yml
package:
  name: mips_lsu

sources:
  - files:
      - src/lsu_pkg.sv
      - src/store_align.sv
      - src/store_buffer.sv
      - src/lsu_control.sv
      - src/load_align.sv
      - src/lsu_top.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_lsu.sv
